// ==== include/decomp_consts.svh ====
`ifndef DECOMP_CONSTS_SVH
`define DECOMP_CONSTS_SVH

// one memory beat and one fifo entry
`define WORD_W         64
`define FIFO_DEPTH     16
`define PTR_W          4   // index bits, pointers carry one extra wrap bit

// compressed word layout, five units of zeros plus value, info nibble on top
`define UNITS_PER_WORD 5
`define UNIT_W         12  // zero count in bits 3:0, value in bits 11:4
`define INFO_LSB       60

// global buffer side
`define PKT_BYTES      8
`define RAW_LEN_W      16  // raw stream length in words

`endif

// ==== logic/decomp_pkg.sv ====
`include "decomp_consts.svh"

package decomp_pkg;

    // raw passes words straight through, zrl expands zero runs
    typedef enum logic {
        MODE_RAW = 1'b0,
        MODE_ZRL = 1'b1
    } fmap_mode_t;

    // one transfer to the global buffer
    typedef struct packed {
        logic [`PKT_BYTES-1:0][7:0] data;        // byte i is the i-th stream byte
        logic [`PKT_BYTES-1:0]      valid_mask;  // contiguous from bit 0
        logic                       last;        // final packet of the stream
    } fmap_packet_t;

    // one compress unit, zeros come out before the value
    typedef struct packed {
        logic [7:0] val;
        logic [3:0] zeros;
    } zrl_unit_t;

    // info nibble in bits 63:60 of every compressed word
    typedef struct packed {
        logic       ends_with_val;  // final unit carries its value too
        logic [2:0] last_unit;      // 7 when the stream goes on past this word
    } zrl_info_t;

endpackage

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/1ns
`include "decomp_consts.svh"

module fetch_ctrl import decomp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  fmap_mode_t            mode_in,
    input  logic [`RAW_LEN_W-1:0] raw_words,
    input  logic                  mem_ack,
    input  logic                  mem_data_valid,
    input  logic [`WORD_W-1:0]    mem_data,
    input  logic                  pop,
    input  logic                  stream_done,
    output logic                  mem_req,
    output fmap_mode_t            mode,
    output logic                  busy,
    output logic                  wr_en
);
    localparam logic [`PTR_W:0] FULL_CREDITS = `FIFO_DEPTH;

    logic [`RAW_LEN_W-1:0] len;        // words to fetch in raw mode
    logic [`RAW_LEN_W-1:0] ack_cnt;
    logic [`PTR_W:0]       credits;    // acked words not yet popped or thrown away
    logic [`PTR_W:0]       credits_nxt;
    logic [`PTR_W:0]       skip_cnt;   // words still in flight from the previous stream
    logic                  end_seen;   // end word of a compressed stream has been written
    logic                  fetch_stop;
    logic                  start_ok;
    logic                  acked;
    logic                  discard;
    zrl_info_t             arr_info;

    assign start_ok   = start & ~busy;
    assign arr_info   = mem_data[`WORD_W-1:`INFO_LSB]; // info nibble of the arriving word
    assign fetch_stop = (mode == MODE_RAW) ? (ack_cnt == len) : end_seen;
    assign mem_req    = busy & ~fetch_stop & (credits != FULL_CREDITS);
    assign acked      = mem_req & mem_ack;

    // anything past the end word or left over from an older stream never reaches the fifo
    assign wr_en   = mem_data_valid & busy & ~end_seen & (skip_cnt == '0);
    assign discard = mem_data_valid & ~wr_en;

    // a credit is taken on ack and handed back on pop or on a dropped arrival
    assign credits_nxt = credits + {{`PTR_W{1'b0}}, acked}
                       - {{`PTR_W{1'b0}}, pop}
                       - {{`PTR_W{1'b0}}, discard};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mode     <= MODE_RAW;
            len      <= '0;
            ack_cnt  <= '0;
            end_seen <= 1'b0;
        end else if (start_ok) begin
            busy     <= 1'b1;
            mode     <= mode_in;   // held for the whole stream
            len      <= raw_words;
            ack_cnt  <= '0;
            end_seen <= 1'b0;
        end else begin
            if (stream_done)
                busy <= 1'b0;      // last packet went out
            if (acked)
                ack_cnt <= ack_cnt + 1'b1;
            if (wr_en && mode == MODE_ZRL && arr_info.last_unit != 3'b111)
                end_seen <= 1'b1;  // this word closes the compressed stream
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits  <= '0;
            skip_cnt <= '0;
        end else begin
            credits <= credits_nxt;
            // fifo is drained at start so every credit left is a late word on its way
            if (start_ok)
                skip_cnt <= credits_nxt;
            else if (discard && skip_cnt != '0)
                skip_cnt <= skip_cnt - 1'b1;
        end
    end

    // every pop and every dropped word must match an earlier ack so the count never wraps
    a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credits_nxt <= FULL_CREDITS)
        else $error("credit count left the range of the fifo");

    // the controller upstream must wait for the last packet before a new start
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy)
        else $error("start arrived while a stream is running");

endmodule

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ns
`include "decomp_consts.svh"

module word_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               wr_en,
    input  logic [`WORD_W-1:0] wr_data,
    input  logic               pop,
    output logic [`WORD_W-1:0] head,
    output logic               empty
);
    logic [`WORD_W-1:0] mem [`FIFO_DEPTH];
    logic [`PTR_W:0]    wr_ptr;  // top bit flips on every wrap
    logic [`PTR_W:0]    rd_ptr;
    logic               full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`PTR_W] != rd_ptr[`PTR_W]) &&
                   (wr_ptr[`PTR_W-1:0] == rd_ptr[`PTR_W-1:0]);
    assign head  = mem[rd_ptr[`PTR_W-1:0]]; // oldest word, read without a cycle of delay

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;   // new stream starts from an empty queue
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr[`PTR_W-1:0]] <= wr_data;
    end

    // credit accounting in the fetch side is what keeps this from firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !clear |-> !full)
        else $error("word written into a full fifo");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop && !clear |-> !empty)
        else $error("pop from an empty fifo");

endmodule

// ==== logic/raw_unpacker.sv ====
`timescale 1ns/1ns
`include "decomp_consts.svh"

module raw_unpacker import decomp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`RAW_LEN_W-1:0] raw_words,
    input  logic [`WORD_W-1:0]    head,
    input  logic                  empty,
    input  logic                  gb_req,
    output logic                  pop,
    output fmap_packet_t          pkt,
    output logic                  pkt_valid
);
    logic [`RAW_LEN_W-1:0] len;   // stream length captured at start
    logic [`RAW_LEN_W-1:0] cnt;   // words loaded so far
    logic                  load;

    // take the head when the register is free or is being handed over now
    assign load = ~empty & (~pkt_valid | gb_req);
    assign pop  = load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
            len       <= '0;
            cnt       <= '0;
        end else if (start) begin
            pkt_valid <= 1'b0;
            len       <= raw_words;
            cnt       <= '0;
        end else if (load) begin
            pkt_valid <= 1'b1;
            cnt       <= cnt + 1'b1;
        end else if (gb_req) begin
            pkt_valid <= 1'b0;   // packet taken and nothing new behind it
        end
    end

    // least significant byte of the word is the first stream byte
    always_ff @(posedge clk) begin
        if (load)
            pkt <= '{data: head, valid_mask: '1, last: (cnt + 1'b1 == len)};
    end

    a_pkt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_valid && !gb_req |=> pkt_valid && $stable(pkt))
        else $error("raw packet changed before the global buffer took it");

endmodule

// ==== logic/zrl_decoder.sv ====
`timescale 1ns/1ns
`include "decomp_consts.svh"

module zrl_decoder import decomp_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [`WORD_W-1:0] head,
    input  logic               empty,
    input  logic               gb_req,
    output logic               pop,
    output fmap_packet_t       pkt,
    output logic               pkt_valid
);
    localparam logic [2:0] LAST_IDX  = `UNITS_PER_WORD - 1;
    localparam logic [3:0] PKT_FULL  = `PKT_BYTES;

    zrl_unit_t [`UNITS_PER_WORD-1:0] units;
    zrl_unit_t                       cur;        // unit being expanded
    zrl_unit_t                       nxt;        // following unit of the same word
    zrl_info_t                       info;
    logic [2:0]                      unit_idx;
    logic [3:0]                      zcnt;       // zeros already sent for this unit
    logic [3:0]                      fill;       // bytes in the packet register
    logic [3:0]                      base_fill;
    logic [3:0]                      new_fill;
    logic [`PKT_BYTES-1:0][7:0]      pkt_data;
    logic                            pkt_last;
    logic                            done;       // stream end reached, wait for start
    logic                            xfer;
    logic                            hold;
    logic                            pend;
    logic                            can_step;
    logic                            step;
    logic                            in_zeros;
    logic                            is_final;
    logic                            silent_end;
    logic                            emit;
    logic                            stream_end;
    logic                            next_emits;
    logic [7:0]                      out_byte;

    assign units = head[`UNITS_PER_WORD*`UNIT_W-1:0];
    assign info  = head[`WORD_W-1:`INFO_LSB];
    assign cur   = units[unit_idx];
    assign nxt   = (unit_idx == LAST_IDX) ? units[0] : units[unit_idx + 3'd1];

    assign xfer = pkt_valid & gb_req;
    assign hold = pkt_valid & ~gb_req;            // finished packet still waiting
    assign pend = ~pkt_valid & (fill == PKT_FULL); // full, but last flag not known yet

    assign in_zeros   = (zcnt != cur.zeros);
    assign is_final   = (info.last_unit == unit_idx);
    assign stream_end = ~in_zeros & is_final;
    // the final unit may close the stream without its value
    assign silent_end = stream_end & ~info.ends_with_val;
    assign emit       = ~silent_end;
    assign out_byte   = in_zeros ? 8'h00 : cur.val;

    assign can_step = ~empty & ~done & ~hold;
    // a pending full packet only lets through a step that adds no byte
    assign step     = can_step & (~pend | silent_end);
    assign pop      = step & ~in_zeros & (is_final | unit_idx == LAST_IDX);

    assign base_fill = xfer ? 4'd0 : fill;        // a transfer frees every slot this cycle
    assign new_fill  = base_fill + {3'b000, emit};

    // does the step after this one still produce a byte, so a full packet may go out now
    always_comb begin
        if (in_zeros)
            next_emits = !(is_final && !info.ends_with_val && zcnt + 4'd1 == cur.zeros);
        else if (unit_idx == LAST_IDX)
            next_emits = 1'b0;   // next word is not visible yet
        else
            next_emits = !(info.last_unit == unit_idx + 3'd1 && nxt.zeros == 4'd0 &&
                           !info.ends_with_val);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
            pkt_last  <= 1'b0;
            fill      <= '0;
            unit_idx  <= '0;
            zcnt      <= '0;
            done      <= 1'b0;
        end else if (start) begin
            pkt_valid <= 1'b0;
            pkt_last  <= 1'b0;
            fill      <= '0;
            unit_idx  <= '0;
            zcnt      <= '0;
            done      <= 1'b0;
        end else begin
            if (xfer) begin
                pkt_valid <= 1'b0;
                pkt_last  <= 1'b0;
                fill      <= '0;
            end
            if (step) begin
                fill <= new_fill;
                if (stream_end) begin
                    pkt_valid <= 1'b1;   // flush whatever is there, partial or full
                    pkt_last  <= 1'b1;
                    done      <= 1'b1;
                end else if (new_fill == PKT_FULL && next_emits) begin
                    pkt_valid <= 1'b1;
                end
                if (in_zeros) begin
                    zcnt <= zcnt + 4'd1;
                end else begin
                    zcnt     <= '0;
                    unit_idx <= pop ? 3'd0 : unit_idx + 3'd1; // wrap to the next word
                end
            end else if (pend && can_step) begin
                pkt_valid <= 1'b1;       // next step has a byte, so this one is not last
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && emit)
            pkt_data[base_fill[2:0]] <= out_byte;
    end

    assign pkt = '{
        data:       pkt_data,
        valid_mask: {`PKT_BYTES{1'b1}} >> (PKT_FULL - fill),
        last:       pkt_last
    };

endmodule

// ==== logic/fmap_decompressor.sv ====
`timescale 1ns/1ns
`include "decomp_consts.svh"

module fmap_decompressor import decomp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  fmap_mode_t            mode_in,
    input  logic [`RAW_LEN_W-1:0] raw_words,
    input  logic [`WORD_W-1:0]    mem_data,
    input  logic                  mem_data_valid,
    input  logic                  mem_ack,
    input  logic                  gb_req,
    output logic                  mem_req,
    output logic                  gb_ack,
    output fmap_packet_t          gb_packet
);
    fmap_mode_t         mode;
    logic               busy;
    logic               start_acc;   // start seen while idle
    logic               wr_en;
    logic               fifo_empty;
    logic               pop;
    logic               stream_done;
    logic [`WORD_W-1:0] head;
    logic               raw_empty;
    logic               raw_pop;
    logic               raw_valid;
    fmap_packet_t       raw_pkt;
    logic               zrl_empty;
    logic               zrl_pop;
    logic               zrl_valid;
    fmap_packet_t       zrl_pkt;

    assign start_acc = start & ~busy;

    // the path not in use sees an empty fifo and stays idle
    assign raw_empty = fifo_empty | (mode != MODE_RAW);
    assign zrl_empty = fifo_empty | (mode != MODE_ZRL);

    assign pop       = (mode == MODE_RAW) ? raw_pop   : zrl_pop;
    assign gb_ack    = (mode == MODE_RAW) ? raw_valid : zrl_valid;
    assign gb_packet = (mode == MODE_RAW) ? raw_pkt   : zrl_pkt;

    assign stream_done = gb_ack & gb_req & gb_packet.last; // handshake on the closing packet

    fetch_ctrl u_fetch (
        .clk, .rst_n, .start, .mode_in, .raw_words, .mem_ack, .mem_data_valid, .mem_data,
        .pop, .stream_done, .mem_req, .mode, .busy, .wr_en
    );

    word_fifo u_fifo (
        .clk, .rst_n, .clear(start_acc), .wr_en, .wr_data(mem_data), .pop,
        .head, .empty(fifo_empty)
    );

    raw_unpacker u_raw (
        .clk, .rst_n, .start(start_acc), .raw_words, .head, .empty(raw_empty), .gb_req,
        .pop(raw_pop), .pkt(raw_pkt), .pkt_valid(raw_valid)
    );

    zrl_decoder u_zrl (
        .clk, .rst_n, .start(start_acc), .head, .empty(zrl_empty), .gb_req,
        .pop(zrl_pop), .pkt(zrl_pkt), .pkt_valid(zrl_valid)
    );

endmodule

// ==== test/tb_fmap_decompressor.sv ====
`timescale 1ns/1ns
`include "decomp_consts.svh"

module tb_fmap_decompressor import decomp_pkg::*; ();
    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    fmap_mode_t            mode_in;
    logic [`RAW_LEN_W-1:0] raw_words;
    logic [`WORD_W-1:0]    mem_data;
    logic                  mem_data_valid;
    logic                  mem_ack;
    logic                  gb_req;
    logic                  mem_req;
    logic                  gb_ack;
    fmap_packet_t          gb_packet;

    logic [31:0]        rng_state = 32'he703;
    logic [7:0]         exp_q[$];           // bytes the global buffer still has to see
    logic [`WORD_W-1:0] src_q[$];           // words of the current stream, handed out per ack
    logic [`WORD_W-1:0] resp_data_q[$];     // acked words waiting for their data strobe
    int                 resp_due_q[$];      // cycle from which each answer may be driven
    int                 word_end_q[$];      // stream byte count at which each word is fully out
    int                 words_acked = 0;    // words of the current stream requested so far
    int                 words_out = 0;      // words whose bytes have all been delivered
    int                 bytes_out = 0;
    int                 word_room = 0;      // words the DUT may hold beyond those delivered
    int                 cyc = 0;
    int                 stall_left = 0;
    logic               last_seen = 1'b0;
    logic               prev_valid = 1'b0;
    logic               prev_req = 1'b0;
    fmap_packet_t       prev_pkt = '0;
    string              test_name = "reset";

    fmap_decompressor uut (
        .clk, .rst_n, .start, .mode_in, .raw_words, .mem_data, .mem_data_valid, .mem_ack,
        .gb_req, .mem_req, .gb_ack, .gb_packet
    );

    always #50 clk = ~clk;

    // lcg step with a little tempering so the low bits are usable
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 15);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [79:0] expected,
                               input logic [79:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic build_raw_stream(input int words);
        logic [`WORD_W-1:0] word;
        src_q.delete();
        for (int w = 0; w < words; w++) begin
            word = {next_rand(), next_rand()};
            src_q.push_back(word);
            for (int b = 0; b < `PKT_BYTES; b++)
                exp_q.push_back(word[b*8 +: 8]);  // low byte goes out first
            word_end_q.push_back((w + 1) * `PKT_BYTES);
        end
    endtask

    task automatic build_zrl_stream(input int words, input logic [2:0] end_unit,
                                    input logic end_val);
        logic [`WORD_W-1:0] word;
        logic [31:0]        r;
        logic [3:0]         zeros;
        logic               final_unit;
        int                 bytes;
        bytes = 0;
        src_q.delete();
        for (int w = 0; w < words; w++) begin
            word = {next_rand(), next_rand()};     // units past the end keep random junk
            if (w == words - 1)
                word[63:60] = {end_val, end_unit};
            else
                word[62:60] = 3'b111;             // stream goes on
            for (int u = 0; u < `UNITS_PER_WORD; u++) begin
                final_unit = (w == words - 1) && (u == int'(end_unit));
                if (w < words - 1 || u <= int'(end_unit)) begin
                    r = next_rand();
                    zeros = r[0] ? r[7:4] : {2'b00, r[5:4]};  // mostly short runs
                    // a stream must carry at least one byte
                    if (final_unit && !end_val && bytes == 0 && zeros == 4'd0)
                        zeros = 4'd1;
                    word[u*`UNIT_W +: 4]     = zeros;
                    word[u*`UNIT_W + 4 +: 8] = r[15:8];
                    for (int z = 0; z < int'(zeros); z++) begin
                        exp_q.push_back(8'h00);
                        bytes++;
                    end
                    if (!final_unit || end_val) begin
                        exp_q.push_back(r[15:8]);
                        bytes++;
                    end
                end
            end
            src_q.push_back(word);
            word_end_q.push_back(bytes);
        end
    endtask

    // one acked request, answered in order after 1 to 6 cycles
    task automatic record_ack();
        logic [`WORD_W-1:0] word;
        int                 due;
        if (src_q.size() > 0) begin
            word = src_q.pop_front();
            words_acked++;
        end else begin
            word = {next_rand(), next_rand()};   // past the end word, must never show up
        end
        due = cyc + 1 + int'(next_rand() % 6);
        if (resp_due_q.size() > 0 && due <= resp_due_q[$])
            due = resp_due_q[$] + 1;             // one strobe per cycle keeps the order
        resp_due_q.push_back(due);
        resp_data_q.push_back(word);
    endtask

    task automatic check_transfer();
        logic [`WORD_W-1:0]    exp_data;
        logic [`WORD_W-1:0]    act_data;
        logic [`PKT_BYTES-1:0] exp_mask;
        int                    rem;
        int                    n;
        rem = exp_q.size();
        if (rem == 0) begin
            abort_run("a packet was delivered after the end of the stream");
        end else begin
            n = (rem < `PKT_BYTES) ? rem : `PKT_BYTES;
            exp_data = '0;
            act_data = '0;
            exp_mask = '0;
            for (int k = 0; k < n; k++) begin
                exp_data[k*8 +: 8] = exp_q.pop_front();
                act_data[k*8 +: 8] = gb_packet.data[k];  // bytes past the mask are don't care
                exp_mask[k]        = 1'b1;
            end
            check_value({test_name, " mask"}, 80'(exp_mask), 80'(gb_packet.valid_mask));
            check_value({test_name, " last"}, 80'(rem <= `PKT_BYTES), 80'(gb_packet.last));
            check_value({test_name, " data"}, 80'(exp_data), 80'(act_data));
            bytes_out = bytes_out + n;
            while (word_end_q.size() > 0 && word_end_q[0] <= bytes_out) begin
                void'(word_end_q.pop_front());
                words_out++;
            end
            if (gb_packet.last)
                last_seen = 1'b1;
        end
    endtask

    // memory and global buffer side inputs change only on the falling edge
    always @(negedge clk) begin
        logic [31:0] r;
        r = next_rand();
        mem_ack = (r[1:0] != 2'b00);
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
            gb_req = 1'b0;
        end else if (r[7:4] == 4'h0) begin
            stall_left = int'(r[13:8]);   // long stretch of back-pressure
            gb_req = 1'b0;
        end else begin
            gb_req = r[2] | r[3];
        end
        if (resp_due_q.size() > 0 && resp_due_q[0] <= cyc) begin
            mem_data_valid = 1'b1;
            mem_data = resp_data_q.pop_front();
            void'(resp_due_q.pop_front());
        end else begin
            mem_data_valid = 1'b0;
        end
    end

    // rising edge sees the values the DUT registers
    always @(posedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (mem_req && mem_ack)
                record_ack();
            if (prev_valid && !prev_req) begin
                check_value({test_name, " held gb_ack"}, 80'(1), 80'(gb_ack));
                check_value({test_name, " held packet"}, 80'(prev_pkt), 80'(gb_packet));
            end
            if (gb_ack && gb_req)
                check_transfer();
            // a requested word not yet delivered sits in the fifo or in the packet register
            if (words_acked - words_out > word_room)
                abort_run({test_name, " requested more words than the FIFO can hold"});
            prev_valid = gb_ack;
            prev_req   = gb_req;
            prev_pkt   = gb_packet;
        end
    end

    initial begin
        int t;
        int words;
        rst_n = 1'b0;
        start = 1'b0;
        mode_in = MODE_RAW;
        raw_words = '0;
        mem_data = '0;
        mem_data_valid = 1'b0;
        mem_ack = 1'b0;
        gb_req = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "idle";
        repeat (20) begin
            @(posedge clk);
            check_value("idle mem_req", 80'(0), 80'(mem_req));
            check_value("idle gb_ack", 80'(0), 80'(gb_ack));
        end

        // modes alternate, compressed streams cover every end unit with and without value
        for (int s = 0; s < 20; s++) begin
            @(posedge clk);
            #10;
            words_acked = 0;
            words_out   = 0;
            bytes_out   = 0;
            word_end_q.delete();
            if (s % 2 == 0) begin
                words = 1 + int'(next_rand() % 40);
                test_name = $sformatf("raw stream %0d", s);
                word_room = `FIFO_DEPTH + 1;   // one more word waits in the packet register
                build_raw_stream(words);
            end else begin
                words = 1 + int'(next_rand() % 6);
                test_name = $sformatf("zrl stream %0d", s);
                // the packet being built can hold the tails of two popped words
                word_room = `FIFO_DEPTH + 2;
                build_zrl_stream(words, 3'((s / 2) % 5), s / 2 >= 5);
            end
            @(negedge clk);
            start = 1'b1;
            mode_in = (s % 2 == 0) ? MODE_RAW : MODE_ZRL;
            raw_words = `RAW_LEN_W'(words);
            @(negedge clk);
            start = 1'b0;
            t = 0;
            while (!last_seen && t < 20000) begin
                @(negedge clk);
                t++;
            end
            if (!last_seen)
                abort_run({test_name, " did not deliver its last packet in 20000 cycles"});
            check_value({test_name, " bytes left"}, 80'(0), 80'(exp_q.size()));
            last_seen = 1'b0;
        end

        // late answers drain, nothing more may come out
        t = 0;
        while (resp_due_q.size() > 0 && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (resp_due_q.size() > 0)
            abort_run("memory answers were still pending at the end of the run");
        repeat (20) @(posedge clk);
        check_value("final gb_ack", 80'(0), 80'(gb_ack));
        check_value("final mem_req", 80'(0), 80'(mem_req));
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== fmap_decompressor.f ====
+incdir+include
logic/decomp_pkg.sv
logic/fetch_ctrl.sv
logic/word_fifo.sv
logic/raw_unpacker.sv
logic/zrl_decoder.sv
logic/fmap_decompressor.sv
test/tb_fmap_decompressor.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the decompressor testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_fmap_decompressor \
        -f fmap_decompressor.f -o tb_sim > build.log 2>&1; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1
